// File: hdl/bridge_pkg.sv
package bridge_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  sram_size_t;   // log2 of byte count
    typedef logic [2:0]  axi_size_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [1:0]  resp_t;

    // read ids, one per cpu port
    localparam axi_id_t ID_INST = 4'd0;
    localparam axi_id_t ID_DATA = 4'd1;

    typedef struct packed {
        logic       wr;
        sram_size_t size;
        addr_t      addr;
        strb_t      wstrb;
        data_t      wdata;
    } sram_req_t;

    typedef struct packed {
        axi_id_t   id;
        addr_t     addr;
        axi_size_t size;
    } ar_t;

    typedef struct packed {
        addr_t     addr;
        axi_size_t size;
    } aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_t;

    typedef struct packed {
        axi_id_t id;
        data_t   data;
        resp_t   resp;
    } r_t;

    typedef struct packed {
        axi_id_t   id;
        addr_t     addr;
        axi_size_t size;
    } rd_cmd_t;

    typedef struct packed {
        addr_t     addr;
        axi_size_t size;
        data_t     data;
        strb_t     strb;
    } wr_cmd_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_BOTH,      // aw and w both pending
        WR_W_ONLY,    // aw done, w pending
        WR_AW_ONLY,   // w done, aw pending
        WR_RESP
    } wr_state_e;

endpackage

// File: hdl/read_channel.sv
`timescale 1ns/10ps

module read_channel (
    input  logic                clk,
    input  logic                reset,
    input  logic                rd_valid,
    input  bridge_pkg::rd_cmd_t rd_cmd,
    output logic                rd_ready,
    output bridge_pkg::ar_t     ar,
    output logic                arvalid,
    input  logic                arready,
    input  bridge_pkg::r_t      r,
    input  logic                rvalid,
    output logic                rready,
    output logic                rd_done,
    output bridge_pkg::axi_id_t rd_id,
    output bridge_pkg::data_t   rd_data
);

    bridge_pkg::rd_state_e state;
    bridge_pkg::rd_state_e state_next;

    logic accept;
    logic ar_hs;
    logic r_hs;

    assign accept = rd_valid && rd_ready;
    assign ar_hs  = arvalid && arready;
    assign r_hs   = rvalid && rready;

    // handshake outputs come straight from the state register
    assign rd_ready = (state == bridge_pkg::RD_IDLE);
    assign arvalid  = (state == bridge_pkg::RD_ADDR);
    assign rready   = (state == bridge_pkg::RD_DATA);

    always_comb begin
        state_next = state;
        case (state)
            bridge_pkg::RD_IDLE: begin
                if (rd_valid) begin
                    state_next = bridge_pkg::RD_ADDR;
                end
            end
            bridge_pkg::RD_ADDR: begin
                if (ar_hs) begin
                    state_next = bridge_pkg::RD_DATA;
                end
            end
            bridge_pkg::RD_DATA: begin
                if (r_hs) begin
                    state_next = bridge_pkg::RD_IDLE;
                end
            end
            default: begin
                state_next = bridge_pkg::RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= bridge_pkg::RD_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ar payload latched once, stays put until arready
    always_ff @(posedge clk) begin
        if (accept) begin
            ar.id   <= rd_cmd.id;
            ar.addr <= rd_cmd.addr;
            ar.size <= rd_cmd.size;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_done <= 1'b0;
        end else begin
            rd_done <= r_hs;    // one cycle after the r beat
        end
    end

    always_ff @(posedge clk) begin
        if (r_hs) begin
            rd_id   <= r.id;
            rd_data <= r.data;
        end
    end

    // address channel must not change under back-pressure
    ar_stable_a: assert property (
        @(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(ar)
    );

endmodule

// File: hdl/write_channel.sv
`timescale 1ns/10ps

module write_channel (
    input  logic                clk,
    input  logic                reset,
    input  logic                wr_valid,
    input  bridge_pkg::wr_cmd_t wr_cmd,
    output logic                wr_ready,
    output bridge_pkg::aw_t     aw,
    output logic                awvalid,
    input  logic                awready,
    output bridge_pkg::w_t      w,
    output logic                wvalid,
    input  logic                wready,
    input  logic                bvalid,
    input  bridge_pkg::resp_t   bresp,
    output logic                bready,
    output logic                wr_done
);

    bridge_pkg::wr_state_e state;
    bridge_pkg::wr_state_e state_next;

    logic accept;
    logic aw_hs;
    logic w_hs;
    logic b_hs;

    assign accept = wr_valid && wr_ready;
    assign aw_hs  = awvalid && awready;
    assign w_hs   = wvalid && wready;
    assign b_hs   = bvalid && bready;

    assign wr_ready = (state == bridge_pkg::WR_IDLE);
    assign awvalid  = (state == bridge_pkg::WR_BOTH) || (state == bridge_pkg::WR_AW_ONLY);
    assign wvalid   = (state == bridge_pkg::WR_BOTH) || (state == bridge_pkg::WR_W_ONLY);
    assign bready   = (state == bridge_pkg::WR_RESP);

    // aw and w finish in any order, or together
    always_comb begin
        state_next = state;
        case (state)
            bridge_pkg::WR_IDLE: begin
                if (wr_valid) begin
                    state_next = bridge_pkg::WR_BOTH;
                end
            end
            bridge_pkg::WR_BOTH: begin
                if (aw_hs && w_hs) begin
                    state_next = bridge_pkg::WR_RESP;
                end else if (aw_hs) begin
                    state_next = bridge_pkg::WR_W_ONLY;
                end else if (w_hs) begin
                    state_next = bridge_pkg::WR_AW_ONLY;
                end
            end
            bridge_pkg::WR_W_ONLY: begin
                if (w_hs) begin
                    state_next = bridge_pkg::WR_RESP;
                end
            end
            bridge_pkg::WR_AW_ONLY: begin
                if (aw_hs) begin
                    state_next = bridge_pkg::WR_RESP;
                end
            end
            bridge_pkg::WR_RESP: begin
                if (b_hs) begin
                    state_next = bridge_pkg::WR_IDLE;
                end
            end
            default: begin
                state_next = bridge_pkg::WR_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= bridge_pkg::WR_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            aw.addr <= wr_cmd.addr;
            aw.size <= wr_cmd.size;
            w.data  <= wr_cmd.data;
            w.strb  <= wr_cmd.strb;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_done <= 1'b0;
        end else begin
            wr_done <= b_hs;
        end
    end

    aw_hold_a: assert property (
        @(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid
    );

    w_hold_a: assert property (
        @(posedge clk) disable iff (reset)
        wvalid && !wready |=> wvalid
    );

    // response wait starts right after the last handshake, nothing left pending
    bready_order_a: assert property (
        @(posedge clk) disable iff (reset)
        $rose(bready) |-> $past((aw_hs || w_hs) && (awready || !awvalid) && (wready || !wvalid))
    );

    // slave memory never signals an error
    bresp_okay_a: assert property (
        @(posedge clk) disable iff (reset)
        b_hs |-> bresp == 2'b00
    );

endmodule

// File: hdl/sram_port_mux.sv
`timescale 1ns/10ps

module sram_port_mux (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inst_req,
    input  logic                  data_req,
    input  bridge_pkg::sram_req_t inst_sram,
    input  bridge_pkg::sram_req_t data_sram,
    output logic                  inst_addr_ok,
    output logic                  inst_data_ok,
    output logic                  data_addr_ok,
    output logic                  data_data_ok,
    output bridge_pkg::data_t     inst_rdata,
    output bridge_pkg::data_t     data_rdata,
    output logic                  rd_valid,
    output bridge_pkg::rd_cmd_t   rd_cmd,
    input  logic                  rd_ready,
    output logic                  wr_valid,
    output bridge_pkg::wr_cmd_t   wr_cmd,
    input  logic                  wr_ready,
    input  logic                  rd_done,
    input  bridge_pkg::axi_id_t   rd_id,
    input  bridge_pkg::data_t     rd_data,
    input  logic                  wr_done
);

    logic inst_busy;
    logic data_busy;
    logic inst_rd_done;
    logic data_rd_done;
    logic data_done;
    logic inst_free;
    logic data_free;
    logic inst_want;
    logic data_rd_want;
    logic inst_go;
    logic data_rd_go;
    logic data_wr_go;

    assign inst_rd_done = rd_done && (rd_id == bridge_pkg::ID_INST);
    assign data_rd_done = rd_done && (rd_id == bridge_pkg::ID_DATA);
    assign data_done    = data_rd_done || wr_done;

    // a port frees up in the cycle its completion is reported
    assign inst_free = !inst_busy || inst_rd_done;
    assign data_free = !data_busy || data_done;

    assign inst_want    = inst_req && inst_free;
    assign data_rd_want = data_req && !data_sram.wr && data_free;
    assign wr_valid     = data_req && data_sram.wr && data_free;

    assign data_rd_go = data_rd_want && rd_ready;
    assign inst_go    = inst_want && rd_ready && !data_rd_want;    // data read wins
    assign data_wr_go = wr_valid && wr_ready;

    assign rd_valid = data_rd_want || inst_want;

    always_comb begin
        if (data_rd_want) begin
            rd_cmd.id   = bridge_pkg::ID_DATA;
            rd_cmd.addr = data_sram.addr;
            rd_cmd.size = {1'b0, data_sram.size};
        end else begin
            rd_cmd.id   = bridge_pkg::ID_INST;
            rd_cmd.addr = inst_sram.addr;
            rd_cmd.size = {1'b0, inst_sram.size};
        end
    end

    assign wr_cmd.addr = data_sram.addr;
    assign wr_cmd.size = {1'b0, data_sram.size};
    assign wr_cmd.data = data_sram.wdata;
    assign wr_cmd.strb = data_sram.wstrb;

    assign inst_addr_ok = inst_go;
    assign data_addr_ok = data_rd_go || data_wr_go;

    assign inst_data_ok = inst_rd_done;
    assign data_data_ok = data_done;     // read or write, only one can be in flight
    assign inst_rdata   = rd_data;       // qualified by the id-selected data_ok
    assign data_rdata   = rd_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_busy <= 1'b0;
        end else if (inst_go) begin
            inst_busy <= 1'b1;
        end else if (inst_rd_done) begin
            inst_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_busy <= 1'b0;
        end else if (data_rd_go || data_wr_go) begin
            data_busy <= 1'b1;
        end else if (data_done) begin
            data_busy <= 1'b0;
        end
    end

    // one data transaction at a time, so the two channels never finish together
    data_done_excl_a: assert property (
        @(posedge clk) disable iff (reset)
        !(data_rd_done && wr_done)
    );

endmodule

// File: hdl/sram_axi_bridge.sv
`timescale 1ns/10ps

module sram_axi_bridge (
    input  logic                  clk,
    input  logic                  reset,

    // cpu side
    input  logic                  inst_req,
    input  logic                  data_req,
    input  bridge_pkg::sram_req_t inst_sram,
    input  bridge_pkg::sram_req_t data_sram,
    output logic                  inst_addr_ok,
    output logic                  inst_data_ok,
    output logic                  data_addr_ok,
    output logic                  data_data_ok,
    output bridge_pkg::data_t     inst_rdata,
    output bridge_pkg::data_t     data_rdata,

    // axi read
    output bridge_pkg::ar_t       ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  bridge_pkg::r_t        r,
    input  logic                  rvalid,
    output logic                  rready,

    // axi write
    output bridge_pkg::aw_t       aw,
    output logic                  awvalid,
    input  logic                  awready,
    output bridge_pkg::w_t        w,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid,
    input  bridge_pkg::resp_t     bresp,
    output logic                  bready
);

    logic                rd_valid;
    logic                rd_ready;
    bridge_pkg::rd_cmd_t rd_cmd;
    logic                rd_done;
    bridge_pkg::axi_id_t rd_id;
    bridge_pkg::data_t   rd_data;

    logic                wr_valid;
    logic                wr_ready;
    bridge_pkg::wr_cmd_t wr_cmd;
    logic                wr_done;

    sram_port_mux mux0 (
        .clk          (clk),
        .reset        (reset),
        .inst_req     (inst_req),
        .data_req     (data_req),
        .inst_sram    (inst_sram),
        .data_sram    (data_sram),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .inst_rdata   (inst_rdata),
        .data_rdata   (data_rdata),
        .rd_valid     (rd_valid),
        .rd_cmd       (rd_cmd),
        .rd_ready     (rd_ready),
        .wr_valid     (wr_valid),
        .wr_cmd       (wr_cmd),
        .wr_ready     (wr_ready),
        .rd_done      (rd_done),
        .rd_id        (rd_id),
        .rd_data      (rd_data),
        .wr_done      (wr_done)
    );

    read_channel rd0 (
        .clk      (clk),
        .reset    (reset),
        .rd_valid (rd_valid),
        .rd_cmd   (rd_cmd),
        .rd_ready (rd_ready),
        .ar       (ar),
        .arvalid  (arvalid),
        .arready  (arready),
        .r        (r),
        .rvalid   (rvalid),
        .rready   (rready),
        .rd_done  (rd_done),
        .rd_id    (rd_id),
        .rd_data  (rd_data)
    );

    write_channel wr0 (
        .clk      (clk),
        .reset    (reset),
        .wr_valid (wr_valid),
        .wr_cmd   (wr_cmd),
        .wr_ready (wr_ready),
        .aw       (aw),
        .awvalid  (awvalid),
        .awready  (awready),
        .w        (w),
        .wvalid   (wvalid),
        .wready   (wready),
        .bvalid   (bvalid),
        .bresp    (bresp),
        .bready   (bready),
        .wr_done  (wr_done)
    );

endmodule

// File: dv/axi_slave_model.sv
`timescale 1ns/10ps

module axi_slave_model (
    input  logic              clk,
    input  logic              reset,
    input  bridge_pkg::ar_t   ar,
    input  logic              arvalid,
    output logic              arready,
    output bridge_pkg::r_t    r,
    output logic              rvalid,
    input  logic              rready,
    input  bridge_pkg::aw_t   aw,
    input  logic              awvalid,
    output logic              awready,
    input  bridge_pkg::w_t    w,
    input  logic              wvalid,
    output logic              wready,
    output logic              bvalid,
    output bridge_pkg::resp_t bresp,
    input  logic              bready
);

    bridge_pkg::data_t mem [0:255];
    bridge_pkg::data_t merged;
    bridge_pkg::addr_t aw_addr;
    bridge_pkg::data_t w_data;
    bridge_pkg::strb_t w_strb;
    logic [7:0]        lfsr;
    logic [1:0]        ar_delay;
    logic [1:0]        aw_delay;
    logic [1:0]        w_delay;
    logic              aw_seen;
    logic              w_seen;

    // fibonacci lfsr, x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // one step per bit taken, 0 to 3 cycles
    task automatic draw_delay(output logic [1:0] d);
        lfsr = lfsr_step(lfsr);
        d[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        d[1] = lfsr[0];
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = i ^ 32'hA5A5_0000;
        end
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        rvalid  = 1'b0;
        bvalid  = 1'b0;
        r       = '0;
        bresp   = 2'b00;    // always okay
    end

    always @(posedge clk) begin
        if (reset) begin
            lfsr = 8'd86;
            draw_delay(ar_delay);
            draw_delay(aw_delay);
            draw_delay(w_delay);
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                rvalid  <= 1'b1;    // data beat right after the address
                r.id    <= ar.id;
                r.data  <= mem[ar.addr[9:2]];
                r.resp  <= 2'b00;
                draw_delay(ar_delay);
            end else if (arvalid) begin
                if (ar_delay == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_delay = ar_delay - 2'd1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end

            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_seen <= 1'b1;
                aw_addr <= aw.addr;
                draw_delay(aw_delay);
            end else if (awvalid) begin
                if (aw_delay == 2'd0) begin
                    awready <= 1'b1;
                end else begin
                    aw_delay = aw_delay - 2'd1;
                end
            end

            if (wvalid && wready) begin
                wready <= 1'b0;
                w_seen <= 1'b1;
                w_data <= w.data;
                w_strb <= w.strb;
                draw_delay(w_delay);
            end else if (wvalid) begin
                if (w_delay == 2'd0) begin
                    wready <= 1'b1;
                end else begin
                    w_delay = w_delay - 2'd1;
                end
            end

            // both halves in, commit the strobed bytes
            if (aw_seen && w_seen && !bvalid) begin
                merged = mem[aw_addr[9:2]];
                for (int b = 0; b < 4; b++) begin
                    if (w_strb[b]) begin
                        merged[8*b +: 8] = w_data[8*b +: 8];
                    end
                end
                mem[aw_addr[9:2]] <= merged;
                aw_seen <= 1'b0;
                w_seen  <= 1'b0;
                bvalid  <= 1'b1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

// File: dv/sram_axi_bridge_tb.sv
`timescale 1ns/10ps

module sram_axi_bridge_tb;

    logic                  clk;
    logic                  reset;
    logic                  inst_req;
    logic                  data_req;
    bridge_pkg::sram_req_t inst_sram;
    bridge_pkg::sram_req_t data_sram;
    logic                  inst_addr_ok;
    logic                  inst_data_ok;
    logic                  data_addr_ok;
    logic                  data_data_ok;
    bridge_pkg::data_t     inst_rdata;
    bridge_pkg::data_t     data_rdata;
    bridge_pkg::ar_t       ar;
    logic                  arvalid;
    logic                  arready;
    bridge_pkg::r_t        r;
    logic                  rvalid;
    logic                  rready;
    bridge_pkg::aw_t       aw;
    logic                  awvalid;
    logic                  awready;
    bridge_pkg::w_t        w;
    logic                  wvalid;
    logic                  wready;
    logic                  bvalid;
    bridge_pkg::resp_t     bresp;
    logic                  bready;

    // one entry per pattern line
    byte               tag_q[$];
    byte               port_q[$];
    byte               op_q[$];
    bridge_pkg::addr_t addr_q[$];
    bridge_pkg::data_t wdata_q[$];
    bridge_pkg::strb_t strb_q[$];
    bridge_pkg::data_t exp_q[$];

    int              errors = 0;
    int              checks = 0;
    int              tests = 0;
    int              inst_accepts = 0;
    int              data_accepts = 0;
    int              inst_oks = 0;
    int              data_oks = 0;
    int              cycles = 0;
    int              cycle_limit = 0;
    logic            ar_waiting = 1'b0;
    bridge_pkg::ar_t ar_held;

    sram_axi_bridge dut0 (
        .clk          (clk),
        .reset        (reset),
        .inst_req     (inst_req),
        .data_req     (data_req),
        .inst_sram    (inst_sram),
        .data_sram    (data_sram),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .inst_rdata   (inst_rdata),
        .data_rdata   (data_rdata),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready),
        .aw           (aw),
        .awvalid      (awvalid),
        .awready      (awready),
        .w            (w),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid),
        .bresp        (bresp),
        .bready       (bready)
    );

    axi_slave_model slave0 (
        .clk     (clk),
        .reset   (reset),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .bready  (bready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    // completions counted mid-cycle, where they are stable
    always @(negedge clk) begin
        if (!reset) begin
            if (inst_data_ok) begin
                inst_oks++;
            end
            if (data_data_ok) begin
                data_oks++;
            end
        end
    end

    // a stalled ar beat has to come back unchanged
    always @(negedge clk) begin
        if (ar_waiting) begin
            checks++;
            if (arvalid !== 1'b1 || ar !== ar_held) begin
                errors++;
                $display("FAIL %0t: ar payload changed while waiting for arready", $time);
            end
        end
        ar_waiting = !reset && arvalid && !arready;
        ar_held    = ar;
    end

    // all requests are word sized, so both address channels carry size 2
    always @(negedge clk) begin
        if (!reset && arvalid) begin
            checks++;
            if (ar.size !== 3'd2) begin
                errors++;
                $display("FAIL %0t: ar size %0d, expected 2", $time, ar.size);
            end
        end
        if (!reset && awvalid) begin
            checks++;
            if (aw.size !== 3'd2) begin
                errors++;
                $display("FAIL %0t: aw size %0d, expected 2", $time, aw.size);
            end
        end
    end

    task automatic load_patterns();
        int                fd;
        int                code;
        int                ch;
        bit                done;
        byte               tag;
        byte               port;
        byte               op;
        bridge_pkg::addr_t addr;
        bridge_pkg::data_t wdata;
        bridge_pkg::strb_t strb;
        bridge_pkg::data_t exp_data;
        fd = $fopen("dv/bridge_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open dv/bridge_patterns.txt");
            return;
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                done = 1'b1;
            end else if (tag == "#") begin
                ch = 0;
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);    // skip comment text
                end
            end else begin
                code = $fscanf(fd, " %c %c %h %h %h %h", port, op, addr, wdata, strb, exp_data);
                if (code != 6) begin
                    errors++;
                    $display("pattern line %0d is malformed", addr_q.size() + 1);
                    done = 1'b1;
                end else begin
                    tag_q.push_back(tag);
                    port_q.push_back(port);
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    wdata_q.push_back(wdata);
                    strb_q.push_back(strb);
                    exp_q.push_back(exp_data);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_idle(input string phase_name);
        checks++;
        if ({arvalid, rready, awvalid, wvalid, bready, inst_addr_ok, data_addr_ok,
             inst_data_ok, data_data_ok} !== 9'b0) begin
            errors++;
            $display("FAIL %0t: bus valids or ok outputs not low %s", $time, phase_name);
        end
    endtask

    // instruction port only reads
    task automatic fetch_inst(input int idx);
        inst_sram.wr    = 1'b0;
        inst_sram.size  = 2'd2;
        inst_sram.addr  = addr_q[idx];
        inst_sram.wstrb = 4'h0;
        inst_sram.wdata = '0;
        inst_req        = 1'b1;
        @(negedge clk);
        while (inst_addr_ok !== 1'b1) begin
            @(negedge clk);
        end
        @(posedge clk);    // accepted on this edge
        #2;
        inst_req = 1'b0;
        inst_accepts++;
        @(negedge clk);
        while (inst_data_ok !== 1'b1) begin
            @(negedge clk);
        end
        checks++;
        if (inst_rdata !== exp_q[idx]) begin
            errors++;
            $display("FAIL %0t: inst read %h returned %h, expected %h",
                     $time, addr_q[idx], inst_rdata, exp_q[idx]);
        end
    endtask

    task automatic access_data(input int idx);
        data_sram.wr    = (op_q[idx] == "W");
        data_sram.size  = 2'd2;
        data_sram.addr  = addr_q[idx];
        data_sram.wstrb = strb_q[idx];
        data_sram.wdata = wdata_q[idx];
        data_req        = 1'b1;
        @(negedge clk);
        while (data_addr_ok !== 1'b1) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        data_req = 1'b0;
        data_accepts++;
        @(negedge clk);
        while (data_data_ok !== 1'b1) begin
            @(negedge clk);
        end
        if (op_q[idx] != "W") begin
            checks++;
            if (data_rdata !== exp_q[idx]) begin
                errors++;
                $display("FAIL %0t: data read %h returned %h, expected %h",
                         $time, addr_q[idx], data_rdata, exp_q[idx]);
            end
        end
    endtask

    initial begin
        int    i;
        int    errs_before;
        bit    paired;
        string note;
        string result;
        reset     = 1'b1;
        inst_req  = 1'b0;
        data_req  = 1'b0;
        inst_sram = '0;
        data_sram = '0;
        load_patterns();
        cycle_limit = 64 * addr_q.size() + 20;

        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            check_idle("during reset");
        end
        @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_idle("after reset");
        end

        i = 0;
        while (i < addr_q.size()) begin
            @(posedge clk);
            #2;
            errs_before = errors;
            paired = (tag_q[i] == "P");
            if (paired && (i + 1 >= addr_q.size() ||
                           port_q[i] != "D" || port_q[i + 1] != "I")) begin
                errors++;
                $display("pattern line %0d is paired but not a data line before an inst line",
                         i + 1);
                paired = 1'b0;
            end
            if (paired) begin
                fork
                    access_data(i);
                    fetch_inst(i + 1);
                join
            end else if (port_q[i] == "D") begin
                access_data(i);
            end else begin
                fetch_inst(i);
            end
            @(posedge clk);
            #2;
            checks++;
            if (inst_oks != inst_accepts || data_oks != data_accepts) begin
                errors++;
                $display("FAIL %0t: data_ok count inst %0d of %0d, data %0d of %0d",
                         $time, inst_oks, inst_accepts, data_oks, data_accepts);
            end
            tests++;
            note = paired ? " with the next line" : "";
            result = (errors == errs_before) ? "passed" : "failed";
            $display("test %0d: line %0d %c %c %h%s %s",
                     tests, i + 1, port_q[i], op_q[i], addr_q[i], note, result);
            i = i + (paired ? 2 : 1);
        end

        // no stray completions after the last test
        repeat (4) @(posedge clk);
        #2;
        checks++;
        if (inst_oks != inst_accepts || data_oks != data_accepts) begin
            errors++;
            $display("FAIL %0t: extra data_ok pulses after the last test", $time);
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sram_axi_bridge.f
hdl/bridge_pkg.sv
hdl/read_channel.sv
hdl/write_channel.sv
hdl/sram_port_mux.sv
hdl/sram_axi_bridge.sv
dv/axi_slave_model.sv
dv/sram_axi_bridge_tb.sv

// File: dv/bridge_patterns.txt
# tag port op addr     wdata    strb expect (hex, expect unused on writes)
# tag S runs alone, tag P runs together with the next line
S I R 00000000 00000000 0 a5a50000
S I R 00000004 00000000 0 a5a50001
S I R 000003fc 00000000 0 a5a500ff
S D R 00000010 00000000 0 a5a50004
S D W 00000020 11223344 3 00000000
S D R 00000020 00000000 0 a5a53344
S D W 00000024 deadbeef c 00000000
S D R 00000024 00000000 0 dead0009
P D W 00000030 cafef00d f 00000000
S I R 00000008 00000000 0 a5a50002
S D R 00000030 00000000 0 cafef00d
P D W 00000034 01020304 6 00000000
S I R 0000000c 00000000 0 a5a50003
S D R 00000034 00000000 0 a502030d
P D R 00000040 00000000 0 a5a50010
S I R 00000044 00000000 0 a5a50011
S I R 00000080 00000000 0 a5a50020
S D W 00000080 00000077 1 00000000
S D R 00000080 00000000 0 a5a50077
S I R 00000080 00000000 0 a5a50077
P D W 00000100 99000000 8 00000000
S I R 00000104 00000000 0 a5a50041
S D R 00000100 00000000 0 99a50040
